/* Makefile */
TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_branch_predictor
FILELIST := src.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf obj_dir

/* design/bht.sv */
/*
 * direction table, one 2-bit counter per entry, indexed by pc[9:2] by default
 * lookup is combinational, training takes effect at the clock edge
 * a lookup of the entry being trained in the same cycle sees the old value
 */
`timescale 1ns/1ps
`default_nettype none

`include "bp_defs.svh"

module bht
    import bp_types_pkg::*;
(
    input  wire                clk,
    input  wire                rst_n,
    input  wire         [31:0] lookup_pc,
    input  wire                update_valid,
    input  wire         [31:0] update_pc,
    input  wire                update_taken,
    output counter_state_t     lookup_state
);

    counter_state_t cnt_q [`BP_BHT_ENTRIES];
    counter_state_t cnt_next;

    logic [`BP_BHT_IDX_W-1:0] rd_idx;
    logic [`BP_BHT_IDX_W-1:0] wr_idx;

    // separate read and write ports
    assign rd_idx = lookup_pc[`BP_BHT_IDX_W+1:2];
    assign wr_idx = update_pc[`BP_BHT_IDX_W+1:2];

    assign lookup_state = cnt_q[rd_idx];

    // one step toward the outcome, saturating at both ends
    always_comb begin
        case (cnt_q[wr_idx])
            strong_nt: begin
                cnt_next = update_taken ? weak_nt : strong_nt;
            end
            weak_nt: begin
                cnt_next = update_taken ? weak_t : strong_nt;
            end
            weak_t: begin
                cnt_next = update_taken ? strong_t : weak_nt;
            end
            default: begin   // strong_t
                cnt_next = update_taken ? strong_t : weak_t;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `BP_BHT_ENTRIES; i++) begin
                cnt_q[i] <= strong_nt;
            end
        end else if (update_valid) begin
            cnt_q[wr_idx] <= cnt_next;
        end
    end

endmodule

`default_nettype wire

/* design/bp_apb_pkg.sv */
/*
 * register map of the predictor APB block
 * offsets outside this list answer with pslverr
 */
`default_nettype none

`include "bp_defs.svh"

package bp_apb_pkg;

    typedef enum logic [`BP_APB_ADDR_W-1:0] {
        reg_ctrl        = 8'h00,  // bit 0 enable
        reg_lookups     = 8'h04,
        reg_resolved    = 8'h08,
        reg_mispredicts = 8'h0C,
        reg_clear       = 8'h10   // write only, any data
    } bp_reg_t;

endpackage

`default_nettype wire

/* design/bp_csr.sv */
/*
 * APB slave, zero wait states, pready tied high
 * holds the predictor enable and three wrapping 32-bit statistics counters
 * a clear write wins over an increment in the same cycle
 */
`timescale 1ns/1ps
`default_nettype none

`include "bp_defs.svh"

module bp_csr
    import bp_apb_pkg::*;
(
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       psel,
    input  wire                       penable,
    input  wire                       pwrite,
    input  wire  [`BP_APB_ADDR_W-1:0] paddr,
    input  wire  [31:0]               pwdata,
    output logic [31:0]               prdata,
    output logic                      pready,
    output logic                      pslverr,
    input  wire                       lookup_event,
    input  wire                       resolve_event,
    input  wire                       mispredict_event,
    output logic                      enable
);

    localparam int STAT_LOOKUPS  = 0;
    localparam int STAT_RESOLVED = 1;
    localparam int STAT_MISPRED  = 2;

    bp_reg_t     reg_sel;
    logic        access;
    logic        mapped;
    logic        wr_en;
    logic        stat_clr;
    logic [31:0] rd_val;
    logic [31:0] stat_q [3];
    logic [2:0]  stat_inc;

    assign reg_sel = bp_reg_t'(paddr);
    assign access  = psel & penable;   // access phase only

    // read mux and address decode
    always_comb begin
        mapped = 1'b1;
        rd_val = 32'd0;
        case (reg_sel)
            reg_ctrl:        rd_val = {31'd0, enable};
            reg_lookups:     rd_val = stat_q[STAT_LOOKUPS];
            reg_resolved:    rd_val = stat_q[STAT_RESOLVED];
            reg_mispredicts: rd_val = stat_q[STAT_MISPRED];
            reg_clear:       rd_val = 32'd0;
            default:         mapped = 1'b0;
        endcase
    end

    assign pready  = 1'b1;
    assign pslverr = access & ~mapped;
    assign prdata  = (access && !pwrite) ? rd_val : 32'd0;

    assign wr_en    = access & pwrite & mapped;
    assign stat_clr = wr_en && (reg_sel == reg_clear);

    // lookups only count while the predictor is on
    assign stat_inc = {mispredict_event, resolve_event, lookup_event & enable};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            enable <= 1'b1;
        end else if (wr_en && (reg_sel == reg_ctrl)) begin
            enable <= pwdata[0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 3; i++) begin
                stat_q[i] <= 32'd0;
            end
        end else begin
            for (int i = 0; i < 3; i++) begin
                if (stat_clr) begin
                    stat_q[i] <= 32'd0;
                end else if (stat_inc[i]) begin
                    stat_q[i] <= stat_q[i] + 32'd1;   // wraps
                end
            end
        end
    end

endmodule

`default_nettype wire

/* design/bp_defs.svh */
/*
 * sizing for the branch predictor tables and the register bus
 * PC bits [1:0] are never used, instructions are word aligned
 * btb tag width must stay equal to 32 - btb index width - 2
 */
`ifndef BP_DEFS_SVH
`define BP_DEFS_SVH

// direction counters
`define BP_BHT_ENTRIES 256
`define BP_BHT_IDX_W   8

// target buffer, direct mapped
`define BP_BTB_ENTRIES 64
`define BP_BTB_IDX_W   6
`define BP_BTB_TAG_W   24

`define BP_APB_ADDR_W  8   // byte offsets into the register block

`endif

/* design/bp_resolve.sv */
/*
 * checks a resolved branch against the prediction the pipeline carried
 * mispredict is a one-cycle pulse, one cycle after the resolve edge
 * redirect_pc holds its last value between resolves
 */
`timescale 1ns/1ps
`default_nettype none

module bp_resolve (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         resolve_valid,
    input  wire  [31:0] resolve_pc,
    input  wire         resolve_taken,
    input  wire  [31:0] resolve_target,
    input  wire         resolve_pred_taken,
    input  wire  [31:0] resolve_pred_target,
    output logic        mispredict,
    output logic [31:0] redirect_pc
);

    logic        dir_wrong;
    logic        tgt_wrong;
    logic        mispredict_d;
    logic [31:0] fall_through;

    assign dir_wrong = resolve_taken != resolve_pred_taken;
    // right direction but wrong place
    assign tgt_wrong = resolve_taken & resolve_pred_taken &
                       (resolve_target != resolve_pred_target);

    assign mispredict_d = resolve_valid & (dir_wrong | tgt_wrong);
    assign fall_through = resolve_pc + 32'd4;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mispredict  <= 1'b0;
            redirect_pc <= 32'd0;
        end else begin
            mispredict <= mispredict_d;   // pulse
            if (resolve_valid) begin
                redirect_pc <= resolve_taken ? resolve_target : fall_through;
            end
        end
    end

endmodule

`default_nettype wire

/* design/bp_types_pkg.sv */
/*
 * predictor types shared by the direction table and the top level
 * the upper counter bit is the predicted direction
 */
`default_nettype none

package bp_types_pkg;

    // 2-bit saturating counter, ordered so that +1 moves toward taken
    typedef enum logic [1:0] {
        strong_nt = 2'b00,
        weak_nt   = 2'b01,
        weak_t    = 2'b10,
        strong_t  = 2'b11
    } counter_state_t;

endpackage

`default_nettype wire

/* design/branch_predictor.sv */
/*
 * branch prediction unit top, bimodal direction plus direct-mapped BTB
 * fetch results are combinational, resolve results come one cycle later
 * no stall and no flush, the core owns both
 */
`timescale 1ns/1ps
`default_nettype none

`include "bp_defs.svh"

module branch_predictor
    import bp_types_pkg::*;
(
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       fetch_valid,
    input  wire  [31:0]               fetch_pc,
    output logic                      pred_taken,
    output logic [31:0]               pred_target,
    output counter_state_t            pred_state,
    output logic                      pred_hit,
    input  wire                       resolve_valid,
    input  wire  [31:0]               resolve_pc,
    input  wire                       resolve_taken,
    input  wire  [31:0]               resolve_target,
    input  wire                       resolve_pred_taken,
    input  wire  [31:0]               resolve_pred_target,
    output logic                      mispredict,
    output logic [31:0]               redirect_pc,
    input  wire                       psel,
    input  wire                       penable,
    input  wire                       pwrite,
    input  wire  [`BP_APB_ADDR_W-1:0] paddr,
    input  wire  [31:0]               pwdata,
    output logic [31:0]               prdata,
    output logic                      pready,
    output logic                      pslverr
);

    counter_state_t lookup_state;
    logic           btb_hit;
    logic [31:0]    btb_target;
    logic           enable;

    bht bht_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .lookup_pc    (fetch_pc),
        .update_valid (resolve_valid),
        .update_pc    (resolve_pc),
        .update_taken (resolve_taken),
        .lookup_state (lookup_state)
    );

    btb btb_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .lookup_pc     (fetch_pc),
        .update_valid  (resolve_valid),
        .update_taken  (resolve_taken),
        .update_pc     (resolve_pc),
        .update_target (resolve_target),
        .hit           (btb_hit),
        .target        (btb_target)
    );

    bp_resolve bp_resolve_inst (
        .clk                 (clk),
        .rst_n               (rst_n),
        .resolve_valid       (resolve_valid),
        .resolve_pc          (resolve_pc),
        .resolve_taken       (resolve_taken),
        .resolve_target      (resolve_target),
        .resolve_pred_taken  (resolve_pred_taken),
        .resolve_pred_target (resolve_pred_target),
        .mispredict          (mispredict),
        .redirect_pc         (redirect_pc)
    );

    bp_csr bp_csr_inst (
        .clk              (clk),
        .rst_n            (rst_n),
        .psel             (psel),
        .penable          (penable),
        .pwrite           (pwrite),
        .paddr            (paddr),
        .pwdata           (pwdata),
        .prdata           (prdata),
        .pready           (pready),
        .pslverr          (pslverr),
        .lookup_event     (fetch_valid),
        .resolve_event    (resolve_valid),
        .mispredict_event (mispredict),
        .enable           (enable)
    );

    // taken needs a known target, so gate the counter with the hit
    assign pred_taken  = enable & btb_hit & lookup_state[1];
    assign pred_target = btb_target;
    assign pred_state  = lookup_state;
    assign pred_hit    = btb_hit;

endmodule

`default_nettype wire

/* design/btb.sv */
/*
 * direct-mapped branch target buffer, full tag of pc[31:8] by default
 * only taken resolves allocate, a not-taken resolve leaves the entry alone
 * target reads as zero on a miss
 */
`timescale 1ns/1ps
`default_nettype none

`include "bp_defs.svh"

module btb (
    input  wire         clk,
    input  wire         rst_n,
    input  wire  [31:0] lookup_pc,
    input  wire         update_valid,
    input  wire         update_taken,
    input  wire  [31:0] update_pc,
    input  wire  [31:0] update_target,
    output logic        hit,
    output logic [31:0] target
);

    logic [`BP_BTB_TAG_W-1:0]   tag_q    [`BP_BTB_ENTRIES];
    logic [31:0]                target_q [`BP_BTB_ENTRIES];
    logic [`BP_BTB_ENTRIES-1:0] valid_q;

    logic [`BP_BTB_IDX_W-1:0] rd_idx;
    logic [`BP_BTB_TAG_W-1:0] rd_tag;
    logic [`BP_BTB_IDX_W-1:0] wr_idx;
    logic [`BP_BTB_TAG_W-1:0] wr_tag;
    logic                     wr_en;

    assign rd_idx = lookup_pc[`BP_BTB_IDX_W+1:2];
    assign rd_tag = lookup_pc[31:`BP_BTB_IDX_W+2];
    assign wr_idx = update_pc[`BP_BTB_IDX_W+1:2];
    assign wr_tag = update_pc[31:`BP_BTB_IDX_W+2];

    assign wr_en = update_valid & update_taken;

    // tag compare only counts on a valid entry
    assign hit    = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
    assign target = hit ? target_q[rd_idx] : 32'd0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (wr_en) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // payload, overwritten on every taken resolve
    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_q[wr_idx]    <= wr_tag;
            target_q[wr_idx] <= update_target;
        end
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+design
design/bp_types_pkg.sv
design/bp_apb_pkg.sv
design/bht.sv
design/btb.sv
design/bp_resolve.sv
design/bp_csr.sv
design/branch_predictor.sv
verif/branch_predictor_props.sv
verif/tb_branch_predictor.sv

/* verif/branch_predictor_props.sv */
/*
 * bus and pulse properties, bound into the predictor top
 * every property is off while rst_n is low
 */
`timescale 1ns/1ps
`default_nettype none

module branch_predictor_props (
    input wire clk,
    input wire rst_n,
    input wire resolve_valid,
    input wire mispredict,
    input wire psel,
    input wire penable,
    input wire pready,
    input wire pslverr
);

    // zero wait states
    pready_high: assert property (@(posedge clk) disable iff (!rst_n) pready)
        else $error("pready went low");

    // a second pulse needs a second resolve
    mispredict_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        mispredict && $past(mispredict) |-> $past(resolve_valid) && $past(resolve_valid, 2))
        else $error("mispredict held high without back-to-back resolves");

    slverr_in_access: assert property (@(posedge clk) disable iff (!rst_n)
        pslverr |-> psel && penable)
        else $error("pslverr raised outside an access phase");

endmodule

bind branch_predictor branch_predictor_props branch_predictor_props_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .resolve_valid (resolve_valid),
    .mispredict    (mispredict),
    .psel          (psel),
    .penable       (penable),
    .pready        (pready),
    .pslverr       (pslverr)
);

`default_nettype wire

/* verif/tb_branch_predictor.sv */
/*
 * random test of the branch predictor against a cycle model
 * inputs change on the falling edge, lookups are checked 1 ns later,
 * registered results on the next falling edge; stops at the first error
 */
`timescale 1ns/1ps
`default_nettype none

`include "bp_defs.svh"

module tb_branch_predictor
    import bp_types_pkg::*, bp_apb_pkg::*;
();

    localparam int RANDOM_CYCLES  = 2000;
    localparam int APB_CYCLES     = 100;
    localparam int TIMEOUT_CYCLES = (RANDOM_CYCLES + APB_CYCLES) * 2;
    localparam int ON_CYCLES      = 1500;
    localparam int OFF_CYCLES     = 300;

    logic clk, rst_n, fetch_valid, pred_taken, pred_hit;
    logic resolve_valid, resolve_taken, resolve_pred_taken, mispredict;
    logic psel, penable, pwrite, pready, pslverr;
    logic [31:0] fetch_pc, pred_target, resolve_pc, resolve_target;
    logic [31:0] resolve_pred_target, redirect_pc, pwdata, prdata;
    logic [`BP_APB_ADDR_W-1:0] paddr;
    counter_state_t pred_state;

    // reference model
    counter_state_t           m_cnt   [`BP_BHT_ENTRIES];
    logic [`BP_BTB_TAG_W-1:0] m_tag   [`BP_BTB_ENTRIES];
    logic [31:0]              m_tgt   [`BP_BTB_ENTRIES];
    logic                     m_valid [`BP_BTB_ENTRIES];
    logic                     m_enable;
    logic [31:0]              m_lookups, m_resolved, m_mispred;
    logic                     exp_mispredict;
    logic [31:0]              exp_redirect;
    logic [31:0]              pool [16];   // pc pool, pairs alias on index
    logic [31:0]              last_resolve_pc;
    integer                   seed;
    int                       cycles = 0;
    int                       err_count = 0;

    branch_predictor branch_predictor_inst (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES)
            stop_on_error($sformatf("timeout, test not done after %0d cycles", cycles));
    end

    task automatic stop_on_error(string msg);
        err_count++;
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_state(string name, counter_state_t got, counter_state_t exp);
        if (got !== exp)
            stop_on_error($sformatf("error %0t: %s = %s, expected %s",
                                    $time, name, got.name(), exp.name()));
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp)
            stop_on_error($sformatf("error %0t: %s = %b, expected %b", $time, name, got, exp));
    endtask

    task automatic check_addr(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp)
            stop_on_error($sformatf("error %0t: %s = %h, expected %h", $time, name, got, exp));
    endtask

    task automatic check_word(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp)
            stop_on_error($sformatf("error %0t: %s = %0d, expected %0d", $time, name, got, exp));
    endtask

    function automatic logic [31:0] rand_word();
        rand_word = $random(seed);
    endfunction

    function automatic logic [31:0] pick_pc();
        logic [31:0] r;
        r = rand_word();
        return pool[r[3:0]];
    endfunction

    function automatic logic model_hit(logic [31:0] pc);
        return m_valid[pc[`BP_BTB_IDX_W+1:2]] &&
               (m_tag[pc[`BP_BTB_IDX_W+1:2]] == pc[31:`BP_BTB_IDX_W+2]);
    endfunction

    function automatic logic [31:0] model_target(logic [31:0] pc);
        return model_hit(pc) ? m_tgt[pc[`BP_BTB_IDX_W+1:2]] : 32'd0;
    endfunction

    function automatic logic model_taken(logic [31:0] pc);
        return m_enable && model_hit(pc) && m_cnt[pc[`BP_BHT_IDX_W+1:2]][1];
    endfunction

    function automatic counter_state_t next_state(counter_state_t s, logic taken);
        if (taken)
            return (s == strong_t) ? strong_t : counter_state_t'(s + 2'd1);
        return (s == strong_nt) ? strong_nt : counter_state_t'(s - 2'd1);
    endfunction

    function automatic logic model_err(logic [`BP_APB_ADDR_W-1:0] a);
        return !(a inside {reg_ctrl, reg_lookups, reg_resolved, reg_mispredicts, reg_clear});
    endfunction

    function automatic logic [31:0] model_reg(logic [`BP_APB_ADDR_W-1:0] a);
        case (a)
            reg_ctrl:        return {31'd0, m_enable};
            reg_lookups:     return m_lookups;
            reg_resolved:    return m_resolved;
            reg_mispredicts: return m_mispred;
            default:         return 32'd0;
        endcase
    endfunction

    // combinational outputs for the inputs of this cycle
    task automatic check_outputs();
        logic access;
        access = psel && penable;
        check_state("pred_state", pred_state, m_cnt[fetch_pc[`BP_BHT_IDX_W+1:2]]);
        check_bit("pred_hit", pred_hit, model_hit(fetch_pc));
        check_addr("pred_target", pred_target, model_target(fetch_pc));
        check_bit("pred_taken", pred_taken, model_taken(fetch_pc));
        check_bit("pready", pready, 1'b1);   // zero wait states
        check_bit("pslverr", pslverr, access && model_err(paddr));
        if (access && !pwrite && !model_err(paddr))
            check_word("prdata", prdata, model_reg(paddr));
    endtask

    // what the DUT does at the rising edge
    task automatic update_model();
        if (exp_mispredict)
            m_mispred = m_mispred + 32'd1;   // pulse of the previous resolve
        if (resolve_valid)
            m_resolved = m_resolved + 32'd1;
        if (fetch_valid && m_enable)
            m_lookups = m_lookups + 32'd1;
        if (psel && penable && pwrite && paddr == reg_clear) begin
            m_lookups  = 32'd0;
            m_resolved = 32'd0;
            m_mispred  = 32'd0;
        end
        if (psel && penable && pwrite && paddr == reg_ctrl)
            m_enable = pwdata[0];
        exp_mispredict = resolve_valid && ((resolve_taken != resolve_pred_taken) ||
            (resolve_taken && resolve_pred_taken && resolve_target != resolve_pred_target));
        if (resolve_valid) begin
            exp_redirect = resolve_taken ? resolve_target : resolve_pc + 32'd4;
            m_cnt[resolve_pc[`BP_BHT_IDX_W+1:2]] =
                next_state(m_cnt[resolve_pc[`BP_BHT_IDX_W+1:2]], resolve_taken);
            if (resolve_taken) begin
                m_valid[resolve_pc[`BP_BTB_IDX_W+1:2]] = 1'b1;
                m_tag[resolve_pc[`BP_BTB_IDX_W+1:2]]   = resolve_pc[31:`BP_BTB_IDX_W+2];
                m_tgt[resolve_pc[`BP_BTB_IDX_W+1:2]]   = resolve_target;
            end
            last_resolve_pc = resolve_pc;
        end
    endtask

    // called at a falling edge with the inputs already set
    task automatic run_cycle();
        #1;
        check_outputs();
        @(posedge clk);
        update_model();
        @(negedge clk);
        check_bit("mispredict", mispredict, exp_mispredict);
        check_addr("redirect_pc", redirect_pc, exp_redirect);
    endtask

    task automatic random_cycle();
        logic [31:0] r;
        r = rand_word();
        fetch_valid    = r[0];
        fetch_pc       = r[1] ? last_resolve_pc : pick_pc();   // revisit the last update
        resolve_valid  = r[2] | r[3];
        resolve_pc     = pick_pc();
        resolve_taken  = r[4];
        resolve_target = r[5] ? resolve_pc + 32'h100 : rand_word() & 32'hffff_fffc;
        if (r[6]) begin
            resolve_pred_taken  = model_taken(resolve_pc);
            resolve_pred_target = model_target(resolve_pc);
        end else begin
            resolve_pred_taken  = r[7];
            resolve_pred_target = r[8] ? resolve_target : resolve_pc + 32'h100;
        end
        run_cycle();
    endtask

    task automatic apb_transfer(logic write, logic [`BP_APB_ADDR_W-1:0] addr,
                                logic [31:0] data);
        fetch_valid   = 1'b0;
        resolve_valid = 1'b0;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = data;
        run_cycle();   // setup
        penable = 1'b1;
        run_cycle();   // access, data checked here
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic read_stats();
        apb_transfer(1'b0, reg_ctrl, 32'd0);
        apb_transfer(1'b0, reg_lookups, 32'd0);
        apb_transfer(1'b0, reg_resolved, 32'd0);
        apb_transfer(1'b0, reg_mispredicts, 32'd0);
    endtask

    initial begin
        seed = 32'heac1;
        rst_n = 1'b0;
        fetch_valid = 1'b0;
        fetch_pc = 32'd0;
        resolve_valid = 1'b0;
        resolve_pc = 32'd0;
        resolve_taken = 1'b0;
        resolve_target = 32'd0;
        resolve_pred_taken = 1'b0;
        resolve_pred_target = 32'd0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = 32'd0;
        for (int i = 0; i < 16; i++)
            pool[i] = 32'h1000_0000 + 32'(i % 8) * 32'h24 + 32'(i / 8) * 32'h400;
        for (int i = 0; i < `BP_BHT_ENTRIES; i++)
            m_cnt[i] = strong_nt;
        for (int i = 0; i < `BP_BTB_ENTRIES; i++)
            m_valid[i] = 1'b0;
        m_enable = 1'b1;
        m_lookups = 32'd0;
        m_resolved = 32'd0;
        m_mispred = 32'd0;
        exp_mispredict = 1'b0;
        exp_redirect = 32'd0;
        last_resolve_pc = pool[0];

        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        read_stats();
        for (int i = 0; i < 16; i++) begin   // cold tables
            fetch_valid = 1'b1;
            fetch_pc    = pool[i];
            run_cycle();
        end
        repeat (ON_CYCLES) random_cycle();
        read_stats();
        apb_transfer(1'b1, reg_ctrl, 32'd0);   // predictor off, training goes on
        repeat (OFF_CYCLES) random_cycle();
        read_stats();
        apb_transfer(1'b1, reg_ctrl, 32'd1);
        repeat (RANDOM_CYCLES - ON_CYCLES - OFF_CYCLES) random_cycle();
        read_stats();
        apb_transfer(1'b1, reg_clear, 32'hffff_ffff);
        read_stats();
        apb_transfer(1'b0, 8'h14, 32'd0);   // unmapped
        apb_transfer(1'b1, 8'h20, 32'd1);
        read_stats();

        if (err_count == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire
